/* stream_buffer.f */
verilog/stream_buffer_pkg.sv
verilog/feature_ram.sv
verilog/window_scan.sv
verilog/stream_buffer.sv
verification/tb_clock.sv
verification/stream_buffer_checker.sv
verification/stream_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the stream buffer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module stream_buffer_tb -Mdir obj_dir -o stream_buffer_sim \
	-f stream_buffer.f \
	&& obj_dir/stream_buffer_sim 2>&1 | tee "$LOG"

grep -qx "STATUS: PASS" "$LOG" \
	&& echo "Simulation passed." \
	|| { echo "Simulation failed."; exit 1; }

/* verification/stream_buffer_tb.sv */
`default_nettype none

module stream_buffer_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import stream_buffer_pkg::*;

	localparam int LINE_LEN       = 4;
	localparam int CHANNELS       = 3;
	localparam int NUM_WINDOWS    = 5;
	localparam int CHANNEL_STRIDE = 4;
	localparam int WINDOW_STRIDE  = 6;
	localparam int RESET_CYCLES   = 3;
	localparam int IDLE_CYCLES    = 3;
	localparam int RESTART_CYCLES = 6;
	localparam int FILL_ROWS      = 12;
	localparam int SCAN_ROWS      = LINE_LEN * CHANNELS * NUM_WINDOWS;
	localparam int NUM_TESTS      = 5;
	localparam int MODEL_DEPTH    = 64;
	// Highest scanned address plus one.
	localparam int SCAN_SPAN = (NUM_WINDOWS - 1) * WINDOW_STRIDE
		+ (CHANNELS - 1) * CHANNEL_STRIDE + LINE_LEN;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + FILL_ROWS + SCAN_ROWS + READ_LATENCY + 20;

	typedef struct packed {
		logic  sel;
		feat_t pool;
		feat_t eltwise;
		addr_t addr;
	} fill_row_t;

	typedef struct packed {
		logic  wen0;
		feat_t ddr;
	} scan_row_t;

	typedef struct packed {
		scan_pos_t pos;
		logic      chk0;  // Bank 0 word known.
		feat_t     f0;
		logic      chk1;
		feat_t     f1;
	} expect_row_t;

	logic      clk;
	logic      i_reset;
	logic      i_start;
	logic      i_wen0;
	feat_t     i_ddr;
	logic      i_wen1;
	addr_t     i_waddr;
	feat_t     i_pool;
	feat_t     i_eltwise;
	logic      i_eltwise_sel;
	feat_t     o_feature_0;
	feat_t     o_feature_1;
	logic      o_valid;
	logic      o_done;
	scan_pos_t o_pos;

	fill_row_t   fill_tab [FILL_ROWS];
	scan_row_t   scan_tab [SCAN_ROWS];
	expect_row_t exp_tab  [SCAN_ROWS];

	int seed;
	int cycle_count;
	int test_errors [1:NUM_TESTS];
	int tests_passed;
	int tests_failed;
	int valid_count;
	int first_valid;
	int last_valid;
	int done_count;
	int compared0;
	int compared1;
	int cyc;
	logic done_seen;

	tb_clock #(
		.PERIOD_NS   (8),
		.RESET_CYCLES(RESET_CYCLES)
	) u_tb_clock (
		.clk    (clk),
		.o_reset(i_reset)
	);

	stream_buffer #(
		.LINE_LEN      (LINE_LEN),
		.CHANNELS      (CHANNELS),
		.NUM_WINDOWS   (NUM_WINDOWS),
		.CHANNEL_STRIDE(CHANNEL_STRIDE),
		.WINDOW_STRIDE (WINDOW_STRIDE)
	) u_stream_buffer (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_start      (i_start),
		.i_wen0       (i_wen0),
		.i_ddr        (i_ddr),
		.i_wen1       (i_wen1),
		.i_waddr      (i_waddr),
		.i_pool       (i_pool),
		.i_eltwise    (i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.o_feature_0  (o_feature_0),
		.o_feature_1  (o_feature_1),
		.o_valid      (o_valid),
		.o_done       (o_done),
		.o_pos        (o_pos)
	);

	// ****************************************
	// Reporting.
	// ****************************************

	task automatic report_mismatch(input int test_num, input string name,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual);
		test_errors[test_num]++;
	endtask

	task automatic report_problem(input int test_num, input string text);
		$display("ERROR: %s", text);
		test_errors[test_num]++;
	endtask

	task automatic finish_test(input int test_num, input string name);
		if (test_errors[test_num] == 0) begin
			$display("test %0d %s: ok", test_num, name);
			tests_passed++;
		end else begin
			$display("test %0d %s: %0d errors", test_num, name, test_errors[test_num]);
			tests_failed++;
		end
	endtask

	// ****************************************
	// Tables and memory model.
	// ****************************************

	task automatic build_tables();
		feat_t bank0_model   [MODEL_DEPTH];
		feat_t bank1_model   [MODEL_DEPTH];
		logic  bank0_written [MODEL_DEPTH];
		logic  bank1_written [MODEL_DEPTH];
		int    row;
		int    a;
		for (int i = 0; i < MODEL_DEPTH; i++) begin
			bank0_model[i]   = '0;
			bank1_model[i]   = '0;
			bank0_written[i] = 1'b0;
			bank1_written[i] = 1'b0;
		end
		for (int i = 0; i < FILL_ROWS; i++) begin
			fill_tab[i].sel     = (i % 2) == 1;  // Alternate the two sources.
			fill_tab[i].pool    = feat_t'($random(seed));
			fill_tab[i].eltwise = feat_t'($random(seed));
			a = (i * 7 + 1) % SCAN_SPAN;
			fill_tab[i].addr = addr_t'(a);
			bank1_model[a]   = fill_tab[i].sel ? fill_tab[i].eltwise : fill_tab[i].pool;
			bank1_written[a] = 1'b1;
		end
		row = 0;
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int c = 0; c < CHANNELS; c++) begin
				for (int o = 0; o < LINE_LEN; o++) begin
					a = w * WINDOW_STRIDE + c * CHANNEL_STRIDE + o;
					scan_tab[row].wen0 = (row % 5) != 2;
					scan_tab[row].ddr  = feat_t'($random(seed));
					if (scan_tab[row].wen0) begin
						bank0_model[a]   = scan_tab[row].ddr;  // Visible to this read.
						bank0_written[a] = 1'b1;
					end
					exp_tab[row].pos.window  = pos_cnt_t'(w);
					exp_tab[row].pos.channel = pos_cnt_t'(c);
					exp_tab[row].pos.offset  = pos_cnt_t'(o);
					exp_tab[row].chk0 = bank0_written[a];
					exp_tab[row].f0   = bank0_model[a];
					exp_tab[row].chk1 = bank1_written[a];
					exp_tab[row].f1   = bank1_model[a];
					row++;
				end
			end
		end
	endtask

	// ****************************************
	// Checks.
	// ****************************************

	task automatic check_idle(input int test_num);
		if (o_valid !== 1'b0) report_mismatch(test_num, "o_valid", 32'h0, 32'(o_valid));
		if (o_done !== 1'b0) report_mismatch(test_num, "o_done", 32'h0, 32'(o_done));
	endtask

	task automatic check_scan_cycle(input int scan_cyc);
		int idx;
		idx = scan_cyc - READ_LATENCY;  // Scan row now at the outputs.
		if (scan_cyc < SCAN_ROWS && o_pos !== exp_tab[scan_cyc].pos) begin
			report_mismatch(2, "o_pos", 32'(exp_tab[scan_cyc].pos), 32'(o_pos));
		end
		if (o_valid === 1'b1) begin
			valid_count++;
			if (first_valid < 0) first_valid = scan_cyc;
			last_valid = scan_cyc;
			if (idx >= 0 && idx < SCAN_ROWS) begin
				if (exp_tab[idx].chk1) begin
					compared1++;
					if (o_feature_1 !== exp_tab[idx].f1) begin
						report_mismatch(2, "o_feature_1", 32'(exp_tab[idx].f1),
							32'(o_feature_1));
					end
				end
				if (exp_tab[idx].chk0) begin
					compared0++;
					if (o_feature_0 !== exp_tab[idx].f0) begin
						report_mismatch(3, "o_feature_0", 32'(exp_tab[idx].f0),
							32'(o_feature_0));
					end
				end
			end else begin
				report_problem(4, "o_valid is high outside the scan window");
			end
		end else if (o_valid !== 1'b0) begin
			report_problem(4, "o_valid is unknown");
		end else if (idx >= 0 && idx < SCAN_ROWS) begin
			report_problem(4, "o_valid is low inside the scan window");
		end
		if (o_done === 1'b1) begin
			done_count++;
			done_seen = 1'b1;
			if (idx != SCAN_ROWS - 1) report_mismatch(5, "o_done row", SCAN_ROWS - 1, idx);
		end else if (o_done !== 1'b0) begin
			report_problem(5, "o_done is unknown");
		end
	endtask

	// ****************************************
	// Timeout.
	// ****************************************

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// ****************************************
	// Main sequence.
	// ****************************************

	initial begin
		int assert_fails;
		i_start       = 1'b0;
		i_wen0        = 1'b0;
		i_ddr         = '0;
		i_wen1        = 1'b0;
		i_waddr       = '0;
		i_pool        = '0;
		i_eltwise     = '0;
		i_eltwise_sel = 1'b0;
		seed          = 32'h4418_af93;
		tests_passed  = 0;
		tests_failed  = 0;
		valid_count   = 0;
		first_valid   = -1;
		last_valid    = -1;
		done_count    = 0;
		compared0     = 0;
		compared1     = 0;
		done_seen     = 1'b0;
		for (int i = 1; i <= NUM_TESTS; i++) test_errors[i] = 0;
		build_tables();

		// Reset, idle and bank 1 fill, all before i_start.
		@(posedge clk);
		repeat (RESET_CYCLES + IDLE_CYCLES) begin
			@(negedge clk);
			check_idle(1);
		end
		for (int i = 0; i < FILL_ROWS; i++) begin
			@(posedge clk);
			i_wen1        <= 1'b1;
			i_waddr       <= fill_tab[i].addr;
			i_pool        <= fill_tab[i].pool;
			i_eltwise     <= fill_tab[i].eltwise;
			i_eltwise_sel <= fill_tab[i].sel;
			@(negedge clk);
			check_idle(1);
		end
		finish_test(1, "idle before start");

		@(posedge clk);
		i_wen1  <= 1'b0;
		i_start <= 1'b1;

		// One scan row per cycle, then drain until o_done.
		cyc = 0;
		while (!done_seen) begin
			@(posedge clk);
			i_start <= 1'b0;
			if (cyc < SCAN_ROWS) begin
				i_wen0 <= scan_tab[cyc].wen0;
				i_ddr  <= scan_tab[cyc].ddr;
			end else begin
				i_wen0 <= 1'b0;
				i_ddr  <= '0;
			end
			@(negedge clk);
			check_scan_cycle(cyc);
			cyc++;
		end

		if (compared1 == 0) report_problem(2, "no bank 1 word was compared");
		finish_test(2, "bank 1 readback");
		if (compared0 == 0) report_problem(3, "no bank 0 word was compared");
		finish_test(3, "bank 0 ddr fill");
		if (first_valid != READ_LATENCY) begin
			report_mismatch(4, "o_valid first", READ_LATENCY, first_valid);
		end
		if (valid_count != SCAN_ROWS) begin
			report_mismatch(4, "o_valid count", SCAN_ROWS, valid_count);
		end
		if (last_valid - first_valid + 1 != valid_count) begin
			report_problem(4, "o_valid was not high on consecutive cycles");
		end
		finish_test(4, "valid window");

		// A second start must be ignored.
		@(posedge clk);
		i_start <= 1'b1;
		@(negedge clk);
		check_idle(5);
		repeat (RESTART_CYCLES) begin
			@(posedge clk);
			i_start <= 1'b0;
			@(negedge clk);
			check_idle(5);
		end
		if (done_count != 1) report_mismatch(5, "o_done count", 1, done_count);
		finish_test(5, "done pulse and restart");

		assert_fails = u_stream_buffer.u_checker.assert_errors;
		$display("tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, assert_fails);
		if (tests_failed == 0 && assert_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/stream_buffer_checker.sv */
`default_nettype none

module stream_buffer_checker #(
	parameter int LINE_LEN    = 4,
	parameter int CHANNELS    = 3,
	parameter int NUM_WINDOWS = 5
) (
	input wire                          clk,
	input wire                          i_reset,
	input wire                          i_valid,
	input wire                          i_done,
	input wire                          i_active,
	input wire stream_buffer_pkg::scan_pos_t i_pos
);

	timeunit 1ns;
	timeprecision 1ps;

	import stream_buffer_pkg::*;

	int assert_errors = 0;  // Read by the testbench.

	// ****************************************
	// Output control.
	// ****************************************

	a_done_with_valid: assert property (@(posedge clk) disable iff (i_reset)
		i_done |-> i_valid)
		else begin
			$error("o_done is high while o_valid is low.");
			assert_errors++;
		end

	a_done_one_cycle: assert property (@(posedge clk) disable iff (i_reset)
		i_done |=> !i_done)
		else begin
			$error("o_done is high for more than one cycle.");
			assert_errors++;
		end

	a_valid_in_reset: assert property (@(posedge clk) i_reset |=> !i_valid)
		else begin
			$error("o_valid is high during reset.");
			assert_errors++;
		end

	// ****************************************
	// Scan position.
	// ****************************************

	a_pos_range: assert property (@(posedge clk) disable iff (i_reset)
		i_active |-> (int'(i_pos.offset) < LINE_LEN) && (int'(i_pos.channel) < CHANNELS)
			&& (int'(i_pos.window) < NUM_WINDOWS))
		else begin
			$error("o_pos field beyond its limit.");
			assert_errors++;
		end

endmodule

bind stream_buffer stream_buffer_checker #(
	.LINE_LEN   (LINE_LEN),
	.CHANNELS   (CHANNELS),
	.NUM_WINDOWS(NUM_WINDOWS)
) u_checker (
	.clk     (clk),
	.i_reset (i_reset),
	.i_valid (o_valid),
	.i_done  (o_done),
	.i_active(scan_active),
	.i_pos   (o_pos)
);

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic o_reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset is released on a rising edge, like every other input.
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/stream_buffer.sv */
`default_nettype none

module stream_buffer #(
	parameter int LINE_LEN       = 4,
	parameter int CHANNELS       = 3,
	parameter int NUM_WINDOWS    = 5,
	parameter int CHANNEL_STRIDE = 4,
	parameter int WINDOW_STRIDE  = 6
) (
	input  wire                          clk,
	input  wire                          i_reset,
	input  wire                          i_start,
	input  wire                          i_wen0,
	input  wire stream_buffer_pkg::feat_t i_ddr,
	input  wire                          i_wen1,
	input  wire stream_buffer_pkg::addr_t i_waddr,
	input  wire stream_buffer_pkg::feat_t i_pool,
	input  wire stream_buffer_pkg::feat_t i_eltwise,
	input  wire                          i_eltwise_sel,
	output stream_buffer_pkg::feat_t     o_feature_0,
	output stream_buffer_pkg::feat_t     o_feature_1,
	output logic                         o_valid,
	output logic                         o_done,
	output stream_buffer_pkg::scan_pos_t o_pos
);

	import stream_buffer_pkg::*;

	// Scan flags that follow the read data down the pipe.
	typedef struct packed {
		logic valid;
		logic done;
	} stream_ctl_t;

	addr_t       scan_addr;
	logic        scan_active;
	logic        scan_last;
	wr_port_t    bank0_wr;
	wr_port_t    bank1_wr;
	stream_ctl_t scan_ctl;

	stream_ctl_t [READ_LATENCY-1:0] ctl_pipe;

	// ****************************************
	// Scanner, shared by both banks.
	// ****************************************

	window_scan #(
		.LINE_LEN      (LINE_LEN),
		.CHANNELS      (CHANNELS),
		.NUM_WINDOWS   (NUM_WINDOWS),
		.CHANNEL_STRIDE(CHANNEL_STRIDE),
		.WINDOW_STRIDE (WINDOW_STRIDE)
	) u_scan (
		.clk     (clk),
		.i_reset (i_reset),
		.i_start (i_start),
		.o_addr  (scan_addr),
		.o_active(scan_active),
		.o_last  (scan_last),
		.o_pos   (o_pos)
	);

	// ****************************************
	// Bank write ports.
	// ****************************************

	// DDR fills bank 0 at the address being scanned.
	always_comb begin
		bank0_wr.en   = i_wen0 && scan_active;
		bank0_wr.addr = scan_addr;
		bank0_wr.data = i_ddr;
	end

	always_comb begin
		bank1_wr.en   = i_wen1;
		bank1_wr.addr = i_waddr;
		bank1_wr.data = i_eltwise_sel ? i_eltwise : i_pool;  // Result source.
	end

	feature_ram u_bank0 (
		.clk    (clk),
		.i_wr   (bank0_wr),
		.i_raddr(scan_addr),
		.o_rdata(o_feature_0)
	);

	feature_ram u_bank1 (
		.clk    (clk),
		.i_wr   (bank1_wr),
		.i_raddr(scan_addr),
		.o_rdata(o_feature_1)
	);

	// ****************************************
	// Valid and done alignment.
	// ****************************************

	assign scan_ctl.valid = scan_active;
	assign scan_ctl.done  = scan_last;

	// Matches the bank read latency.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			ctl_pipe <= '0;
		end else begin
			ctl_pipe <= {ctl_pipe[READ_LATENCY-2:0], scan_ctl};
		end
	end

	assign o_valid = ctl_pipe[READ_LATENCY-1].valid;
	assign o_done  = ctl_pipe[READ_LATENCY-1].done;  // With the last word.

endmodule

`default_nettype wire

/* verilog/window_scan.sv */
`default_nettype none

module window_scan #(
	parameter int LINE_LEN       = 4,
	parameter int CHANNELS       = 3,
	parameter int NUM_WINDOWS    = 5,
	parameter int CHANNEL_STRIDE = 4,
	parameter int WINDOW_STRIDE  = 6
) (
	input  wire                          clk,
	input  wire                          i_reset,
	input  wire                          i_start,
	output stream_buffer_pkg::addr_t     o_addr,
	output logic                         o_active,
	output logic                         o_last,
	output stream_buffer_pkg::scan_pos_t o_pos
);

	import stream_buffer_pkg::*;

	localparam pos_cnt_t LAST_OFFSET  = pos_cnt_t'(LINE_LEN - 1);
	localparam pos_cnt_t LAST_CHANNEL = pos_cnt_t'(CHANNELS - 1);
	localparam pos_cnt_t LAST_WINDOW  = pos_cnt_t'(NUM_WINDOWS - 1);
	localparam addr_t    CH_STEP      = addr_t'(CHANNEL_STRIDE);
	localparam addr_t    WIN_STEP     = addr_t'(WINDOW_STRIDE);

	scan_pos_t pos;
	addr_t     win_base;  // window * WINDOW_STRIDE.
	addr_t     ch_base;   // channel * CHANNEL_STRIDE.
	logic      run;
	logic      finished;
	logic      end_of_line;
	logic      end_of_window;
	logic      end_of_scan;

	assign end_of_line   = (pos.offset == LAST_OFFSET);
	assign end_of_window = end_of_line && (pos.channel == LAST_CHANNEL);
	assign end_of_scan   = end_of_window && (pos.window == LAST_WINDOW);

	// ****************************************
	// Run control.
	// ****************************************

	// One scan per reset.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			run      <= 1'b0;
			finished <= 1'b0;
		end else if (run) begin
			if (end_of_scan) begin
				run      <= 1'b0;
				finished <= 1'b1;
			end
		end else if (i_start && !finished) begin
			run <= 1'b1;
		end
	end

	// ****************************************
	// Position counters.
	// ****************************************

	always_ff @(posedge clk) begin
		if (i_reset) begin
			pos      <= '0;
			win_base <= '0;
			ch_base  <= '0;
		end else if (run) begin
			if (end_of_scan) begin
				pos      <= '0;  // Park at the origin.
				win_base <= '0;
				ch_base  <= '0;
			end else if (end_of_window) begin
				pos.window  <= pos.window + 1'b1;
				pos.channel <= '0;
				pos.offset  <= '0;
				win_base    <= win_base + WIN_STEP;
				ch_base     <= '0;
			end else if (end_of_line) begin
				pos.channel <= pos.channel + 1'b1;
				pos.offset  <= '0;
				ch_base     <= ch_base + CH_STEP;
			end else begin
				pos.offset <= pos.offset + 1'b1;
			end
		end
	end

	assign o_addr   = win_base + ch_base + addr_t'(pos.offset);
	assign o_active = run;
	assign o_last   = run && end_of_scan;  // Last position.
	assign o_pos    = pos;

endmodule

`default_nettype wire

/* verilog/feature_ram.sv */
`default_nettype none

module feature_ram (
	input  wire                              clk,
	input  wire stream_buffer_pkg::wr_port_t i_wr,
	input  wire stream_buffer_pkg::addr_t    i_raddr,
	output stream_buffer_pkg::feat_t         o_rdata
);

	import stream_buffer_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	feat_t mem [DEPTH];

	addr_t raddr_q;  // Stage 1.
	feat_t array_q;  // Stage 2.
	feat_t rdata_q;  // Stage 3.

	// ****************************************
	// Write port.
	// ****************************************

	always_ff @(posedge clk) begin
		if (i_wr.en) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// ****************************************
	// Read pipeline.
	// ****************************************

	// The array is read one edge after the address is captured, so a write
	// presented with the same address is already in the array.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		array_q <= mem[raddr_q];
		rdata_q <= array_q;
	end

	assign o_rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/stream_buffer_pkg.sv */
`default_nettype none

package stream_buffer_pkg;

	// ****************************************
	// Widths and depths.
	// ****************************************

	localparam int DATA_W = 16; // Feature word.
	localparam int ADDR_W = 14; // Bank holds 2**ADDR_W words.
	localparam int POS_W  = 8;  // One scan counter.

	// Cycles from read address to data at the bank output.
	localparam int READ_LATENCY = 3;

	// ****************************************
	// Types.
	// ****************************************

	typedef logic [DATA_W-1:0] feat_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [POS_W-1:0]  pos_cnt_t;

	// One bank write request.
	typedef struct packed {
		logic  en;
		addr_t addr;
		feat_t data;
	} wr_port_t;

	// Window is outermost, offset runs fastest.
	typedef struct packed {
		pos_cnt_t window;
		pos_cnt_t channel;
		pos_cnt_t offset;
	} scan_pos_t;

endpackage

`default_nettype wire
